// ==== Makefile ====
# Verilator build for the ALU pipeline
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= alu_pipe_tb
RTL_TOP   ?= alu_pipe
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

# lint the RTL top on its own, then the testbench with the RTL
lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+rtl --top-module $(RTL_TOP) \
		rtl/alu_op_pkg.sv rtl/alu_slice_pkg.sv rtl/alu_slice_table.sv \
		rtl/alu_slice_stage.sv rtl/alu_pipe.sv
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass or fail comes from the log, not from the simulator exit code
sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+rtl
rtl/alu_op_pkg.sv
rtl/alu_slice_pkg.sv
rtl/alu_slice_table.sv
rtl/alu_slice_stage.sv
rtl/alu_pipe.sv
tests/alu_pipe_tb.sv

// ==== rtl/alu_consts.svh ====
// ALU datapath constants
// operand width plus the widths and offsets of the three cascaded slices

`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// full operand and result width
`define ALU_WIDTH 16

// slice widths, low and middle are 6 bits, top is 4
`define ALU_LOW_BITS 6
`define ALU_MID_BITS 6
`define ALU_TOP_BITS 4

// bit offset of each slice inside the 16-bit word
`define ALU_MID_LSB 6
`define ALU_TOP_LSB 12

// width of one slice table word, same as the 8-bit rom data bus
`define ALU_SLICE_WORD_BITS 8

`endif

// ==== rtl/alu_op_pkg.sv ====
// ALU operation types
// operation encoding and the position of a slice in the cascade
`default_nettype none

package alu_op_pkg;

   //////////////////////////////
   // operation encoding
   //////////////////////////////
   // the microcode drives these 3 bits directly
   typedef enum logic [2:0] {
      op_add   = 3'd0,
      op_adc   = 3'd1,
      op_sub   = 3'd2,
      op_sbc   = 3'd3,
      op_and   = 3'd4,
      op_or    = 3'd5,
      op_xor   = 3'd6,
      op_passb = 3'd7
   } alu_op_e;

   // where a slice sits in the carry chain
   typedef enum logic [1:0] {
      pos_low = 2'd0,
      pos_mid = 2'd1,
      pos_top = 2'd2
   } slice_pos_e;

endpackage

`default_nettype wire

// ==== rtl/alu_pipe.sv ====
// ALU pipeline top
// three slice stages in a chain, result three cycles after the strobe
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_pipe
   import alu_op_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_valid,
   input  alu_op_e               op,
   input  logic [`ALU_WIDTH-1:0] a,
   input  logic [`ALU_WIDTH-1:0] b,
   input  logic                  fl,
   output logic                  out_valid,
   output logic [`ALU_WIDTH-1:0] y,
   output logic                  set_l,
   output logic                  l_out,
   output logic                  set_v,
   output logic                  v_out
);

   //////////////////////////////
   // low to middle
   //////////////////////////////
   logic                  v1;
   alu_op_e               op1;
   logic                  fl1;
   logic                  c1;
   logic [`ALU_WIDTH-1:0] a1;
   logic [`ALU_WIDTH-1:0] b1;
   logic [`ALU_WIDTH-1:0] y1;

   // middle to top
   logic                  v2;
   alu_op_e               op2;
   logic                  fl2;
   logic                  c2;
   logic [`ALU_WIDTH-1:0] a2;
   logic [`ALU_WIDTH-1:0] b2;
   logic [`ALU_WIDTH-1:0] y2;

   // low slice, carry comes from op and link so carry_in is tied off
   alu_slice_stage #(.POS(pos_low)) u_low (
      .clk(clk), .rst_n(rst_n),
      .in_valid(in_valid), .op_in(op), .fl_in(fl), .carry_in(1'b0),
      .a_in(a), .b_in(b), .y_in('0),
      .out_valid(v1), .op_out(op1), .fl_out(fl1), .carry_out(c1),
      .a_out(a1), .b_out(b1), .y_out(y1),
      .set_l(), .l_out(), .set_v(), .v_out()
   );

   alu_slice_stage #(.POS(pos_mid)) u_mid (
      .clk(clk), .rst_n(rst_n),
      .in_valid(v1), .op_in(op1), .fl_in(fl1), .carry_in(c1),
      .a_in(a1), .b_in(b1), .y_in(y1),
      .out_valid(v2), .op_out(op2), .fl_out(fl2), .carry_out(c2),
      .a_out(a2), .b_out(b2), .y_out(y2),
      .set_l(), .l_out(), .set_v(), .v_out()
   );

   // top slice drives the result and both flags
   alu_slice_stage #(.POS(pos_top)) u_top (
      .clk(clk), .rst_n(rst_n),
      .in_valid(v2), .op_in(op2), .fl_in(fl2), .carry_in(c2),
      .a_in(a2), .b_in(b2), .y_in(y2),
      .out_valid(out_valid), .op_out(), .fl_out(), .carry_out(),
      .a_out(), .b_out(), .y_out(y),
      .set_l(set_l), .l_out(l_out), .set_v(set_v), .v_out(v_out)
   );

endmodule

`default_nettype wire

// ==== rtl/alu_slice_pkg.sv ====
// ALU slice word type
// one 8-bit table word, read as a chain word or as the top word with flags
`default_nettype none

`include "alu_consts.svh"

package alu_slice_pkg;

   //////////////////////////////
   // slice table word
   //////////////////////////////
   typedef union packed {
      // raw rom data
      logic [`ALU_SLICE_WORD_BITS-1:0] raw;
      // low and middle slices
      struct packed {
         logic                     spare;
         logic                     carry;
         logic [`ALU_LOW_BITS-1:0] res;
      } chain;
      // top slice, flag pairs are strobe then value
      struct packed {
         logic                     set_l;
         logic                     l;
         logic                     set_v;
         logic                     v;
         logic [`ALU_TOP_BITS-1:0] res;
      } top;
   } slice_word_u;

endpackage

`default_nettype wire

// ==== rtl/alu_slice_stage.sv ====
// ALU slice stage
// one registered pipeline stage around a slice table
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_slice_stage
   import alu_op_pkg::*, alu_slice_pkg::*;
#(
   parameter slice_pos_e POS = pos_low
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_valid,
   input  alu_op_e               op_in,
   input  logic                  fl_in,
   input  logic                  carry_in,
   input  logic [`ALU_WIDTH-1:0] a_in,
   input  logic [`ALU_WIDTH-1:0] b_in,
   input  logic [`ALU_WIDTH-1:0] y_in,
   output logic                  out_valid,
   output alu_op_e               op_out,
   output logic                  fl_out,
   output logic                  carry_out,
   output logic [`ALU_WIDTH-1:0] a_out,
   output logic [`ALU_WIDTH-1:0] b_out,
   output logic [`ALU_WIDTH-1:0] y_out,
   output logic                  set_l,
   output logic                  l_out,
   output logic                  set_v,
   output logic                  v_out
);

   // field position and width of this slice
   localparam int LSB = (POS == pos_top) ? `ALU_TOP_LSB :
                        (POS == pos_mid) ? `ALU_MID_LSB : 0;
   localparam int W   = (POS == pos_top) ? `ALU_TOP_BITS :
                        (POS == pos_mid) ? `ALU_MID_BITS : `ALU_LOW_BITS;

   logic                     cin;
   logic [`ALU_LOW_BITS-1:0] a_bits;
   logic [`ALU_LOW_BITS-1:0] b_bits;
   slice_word_u              word;
   logic [`ALU_WIDTH-1:0]    y_next;
   logic                     carry_next;
   logic                     set_l_next;
   logic                     l_next;
   logic                     set_v_next;
   logic                     v_next;

   // operand field, zero extended to the table port
   assign a_bits = `ALU_LOW_BITS'(a_in[LSB +: W]);
   assign b_bits = `ALU_LOW_BITS'(b_in[LSB +: W]);

   // carry into the chain
   if (POS == pos_low) begin : g_cin_low
      always_comb begin
         case (op_in)
            op_add:  cin = 1'b0;
            op_sub:  cin = 1'b1;
            // adc, sbc use the link, logic ops carry it through
            default: cin = fl_in;
         endcase
      end
   end else begin : g_cin_chain
      assign cin = carry_in;
   end

   alu_slice_table #(
      .POS(POS)
   ) u_table (
      .op      (op_in),
      .carry_in(cin),
      .a_bits  (a_bits),
      .b_bits  (b_bits),
      .word    (word)
   );

   //////////////////////////////
   // decode the table word
   //////////////////////////////
   if (POS == pos_top) begin : g_dec_top
      always_comb begin
         y_next            = y_in;
         y_next[LSB +: W]  = word.top.res;
         carry_next        = word.top.l;
         set_l_next        = word.top.set_l;
         l_next            = word.top.l;
         set_v_next        = word.top.set_v;
         v_next            = word.top.v;
      end
   end else begin : g_dec_chain
      always_comb begin
         y_next            = y_in;
         y_next[LSB +: W]  = word.chain.res;
         carry_next        = word.chain.carry;
         // no flags below the top slice
         set_l_next        = 1'b0;
         l_next            = 1'b0;
         set_v_next        = 1'b0;
         v_next            = 1'b0;
      end
   end

   //////////////////////////////
   // stage registers
   //////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         op_out    <= op_add;
         fl_out    <= 1'b0;
         carry_out <= 1'b0;
         a_out     <= '0;
         b_out     <= '0;
         y_out     <= '0;
         set_l     <= 1'b0;
         l_out     <= 1'b0;
         set_v     <= 1'b0;
         v_out     <= 1'b0;
      end else begin
         // valid follows the strobe every cycle
         out_valid <= in_valid;
         if (in_valid) begin
            op_out    <= op_in;
            fl_out    <= fl_in;
            carry_out <= carry_next;
            a_out     <= a_in;
            b_out     <= b_in;
            y_out     <= y_next;
            set_l     <= set_l_next;
            l_out     <= l_next;
            set_v     <= set_v_next;
            v_out     <= v_next;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/alu_slice_table.sv ====
// ALU slice table
// combinational replacement for one cascaded lookup rom
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_slice_table
   import alu_op_pkg::*, alu_slice_pkg::*;
#(
   parameter slice_pos_e POS = pos_low
) (
   input  alu_op_e                  op,
   input  logic                     carry_in,
   input  logic [`ALU_LOW_BITS-1:0] a_bits,
   input  logic [`ALU_LOW_BITS-1:0] b_bits,
   output slice_word_u              word
);

   // live width of this slice
   localparam int W = (POS == pos_top) ? `ALU_TOP_BITS :
                      (POS == pos_mid) ? `ALU_MID_BITS : `ALU_LOW_BITS;

   logic         is_sub;
   logic         is_arith;
   logic [W-1:0] a_w;
   logic [W-1:0] b_w;
   logic [W-1:0] b_eff;
   logic [W-1:0] r_logic;
   logic [W-1:0] r;
   logic [W:0]   sum;

   //////////////////////////////
   // slice arithmetic
   //////////////////////////////
   always_comb begin
      a_w      = a_bits[W-1:0];
      b_w      = b_bits[W-1:0];
      is_sub   = (op == op_sub) || (op == op_sbc);
      is_arith = (op == op_add) || (op == op_adc) || is_sub;
      // subtract is a plus not-b plus carry-in
      b_eff    = is_sub ? ~b_w : b_w;
      sum      = {1'b0, a_w} + {1'b0, b_eff} + {{W{1'b0}}, carry_in};
      case (op)
         op_and:  r_logic = a_w & b_w;
         op_or:   r_logic = a_w | b_w;
         op_xor:  r_logic = a_w ^ b_w;
         // pass b, also covers the arith codes
         default: r_logic = b_w;
      endcase
      r = is_arith ? sum[W-1:0] : r_logic;
   end

   //////////////////////////////
   // word packing
   //////////////////////////////
   if (POS == pos_top) begin : g_top
      always_comb begin
         word           = '0;
         word.top.res   = r;
         // L is the carry out, inverted borrow on subtract
         word.top.set_l = is_arith;
         word.top.l     = is_arith & sum[W];
         // signed overflow, operand signs agree but result sign differs
         word.top.set_v = is_arith;
         word.top.v     = is_arith & (a_w[W-1] == b_eff[W-1]) & (r[W-1] != a_w[W-1]);
      end
   end else begin : g_chain
      always_comb begin
         word.raw         = '0;
         word.chain.res   = r;
         // logic ops hand the incoming carry straight up the chain
         word.chain.carry = is_arith ? sum[W] : carry_in;
      end
   end

endmodule

`default_nettype wire

// ==== tests/alu_pipe_tb.sv ====
// ALU pipeline testbench
// directed and random items against a reference model, three cycle latency check
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_pipe_tb
   import alu_op_pkg::*;
;

   localparam int NUM_DIRECTED   = 16;
   localparam int NUM_RANDOM     = 600;
   localparam int LATENCY        = 3;
   // two cycles per item at most, plus pipeline drain and some slack
   localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM + LATENCY) * 2 + 100;

   logic                  clk;
   logic                  rst_n;
   logic                  in_valid;
   alu_op_e               op;
   logic [`ALU_WIDTH-1:0] a;
   logic [`ALU_WIDTH-1:0] b;
   logic                  fl;
   logic                  out_valid;
   logic [`ALU_WIDTH-1:0] y;
   logic                  set_l;
   logic                  l_out;
   logic                  set_v;
   logic                  v_out;

   // expected word is {y, set_l, l, set_v, v}
   logic [`ALU_WIDTH+3:0] exp_q[$];
   int                    stamp_q[$];
   int                    cycle   = 0;
   int                    sent    = 0;
   int                    checked = 0;
   integer                seed    = 96400;

   alu_pipe i_dut (
      .clk(clk), .rst_n(rst_n),
      .in_valid(in_valid), .op(op), .a(a), .b(b), .fl(fl),
      .out_valid(out_valid), .y(y),
      .set_l(set_l), .l_out(l_out), .set_v(set_v), .v_out(v_out)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////
   // reference model and checks
   //////////////////////////////
   function automatic logic [`ALU_WIDTH+3:0] alu_model(alu_op_e m_op,
         logic [`ALU_WIDTH-1:0] m_a, logic [`ALU_WIDTH-1:0] m_b, logic m_fl);
      logic [`ALU_WIDTH:0]   sum;
      logic [`ALU_WIDTH-1:0] b_eff;
      logic [`ALU_WIDTH-1:0] res;
      logic                  cin;
      logic                  arith;
      arith = (m_op == op_add) || (m_op == op_adc) || (m_op == op_sub) || (m_op == op_sbc);
      // subtract is a plus not-b plus carry-in
      b_eff = ((m_op == op_sub) || (m_op == op_sbc)) ? ~m_b : m_b;
      case (m_op)
         op_add:  cin = 1'b0;
         op_sub:  cin = 1'b1;
         default: cin = m_fl;
      endcase
      sum = {1'b0, m_a} + {1'b0, b_eff} + {{`ALU_WIDTH{1'b0}}, cin};
      case (m_op)
         op_and:   res = m_a & m_b;
         op_or:    res = m_a | m_b;
         op_xor:   res = m_a ^ m_b;
         op_passb: res = m_b;
         default:  res = sum[`ALU_WIDTH-1:0];
      endcase
      return {res, arith, arith & sum[`ALU_WIDTH], arith,
              arith & (m_a[`ALU_WIDTH-1] == b_eff[`ALU_WIDTH-1]) &
              (res[`ALU_WIDTH-1] != m_a[`ALU_WIDTH-1])};
   endfunction

   task automatic abort_run(string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_word(string name, logic [`ALU_WIDTH-1:0] got,
         logic [`ALU_WIDTH-1:0] exp);
      if (got !== exp)
         abort_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_op_flag(string name, logic got, logic exp);
      if (got !== exp)
         abort_run($sformatf("ERROR at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////
   // one strobe on the next falling edge, expected result goes in the queue
   task automatic send_item(alu_op_e s_op, logic [`ALU_WIDTH-1:0] s_a,
         logic [`ALU_WIDTH-1:0] s_b, logic s_fl);
      @(negedge clk);
      in_valid = 1'b1;
      op       = s_op;
      a        = s_a;
      b        = s_b;
      fl       = s_fl;
      exp_q.push_back(alu_model(s_op, s_a, s_b, s_fl));
      stamp_q.push_back(cycle);
      sent++;
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   // cycle count and watchdog
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYCLES)
         abort_run($sformatf("timeout after %0d cycles, the run hung with %0d of %0d items checked",
                             cycle, checked, sent));
   end

   //////////////////////////////
   // compare process
   //////////////////////////////
   // outputs change on the rising edge, so sample them on the falling edge
   always @(negedge clk) begin : compare_results
      logic [`ALU_WIDTH+3:0] exp;
      int                    stamp;
      if (out_valid) begin
         if (exp_q.size() == 0)
            abort_run("out_valid went high with no item in flight");
         exp   = exp_q.pop_front();
         stamp = stamp_q.pop_front();
         if (cycle != stamp + LATENCY)
            abort_run($sformatf("ERROR at %0t: out_valid cycle got %0d expected %0d",
                                $time, cycle, stamp + LATENCY));
         check_word("y", y, exp[`ALU_WIDTH+3:4]);
         check_op_flag("set_l", set_l, exp[3]);
         check_op_flag("set_v", set_v, exp[1]);
         // flag values only mean something while their strobe is up
         if (exp[3])
            check_op_flag("l_out", l_out, exp[2]);
         if (exp[1])
            check_op_flag("v_out", v_out, exp[0]);
         checked++;
      end
   end

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin : main_seq
      logic [2:0] op_code;
      int         rand_sent;
      rand_sent = 0;
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      op        = op_add;
      a         = '0;
      b         = '0;
      fl        = 1'b0;
      // outputs stay quiet through reset and the cycle after it
      repeat (4) begin
         @(negedge clk);
         check_op_flag("out_valid", out_valid, 1'b0);
         check_op_flag("set_l", set_l, 1'b0);
         check_op_flag("set_v", set_v, 1'b0);
      end
      rst_n = 1'b1;
      @(negedge clk);
      check_op_flag("out_valid", out_valid, 1'b0);
      check_op_flag("set_l", set_l, 1'b0);
      check_op_flag("set_v", set_v, 1'b0);

      // carries across both slice boundaries
      send_item(op_add, 16'hFFFF, 16'h0001, 1'b0);
      send_item(op_add, 16'h003F, 16'h0001, 1'b0);
      send_item(op_add, 16'h0FFF, 16'h0001, 1'b0);
      send_item(op_adc, 16'h0FFF, 16'h0000, 1'b1);
      send_item(op_adc, 16'hFFFF, 16'h0000, 1'b1);
      // borrow cases, 0 - 1 wraps with L low
      send_item(op_sub, 16'h0000, 16'h0001, 1'b0);
      send_item(op_sub, 16'h1234, 16'h0234, 1'b0);
      send_item(op_sub, 16'h8000, 16'h0001, 1'b0);
      send_item(op_sbc, 16'h0010, 16'h0010, 1'b0);
      send_item(op_sbc, 16'h0010, 16'h0010, 1'b1);
      // logic ops leave both flags alone
      send_item(op_and, 16'hA5C3, 16'h0FF0, 1'b1);
      send_item(op_or, 16'hA5C3, 16'h0FF0, 1'b0);
      send_item(op_xor, 16'hA5C3, 16'h0FF0, 1'b1);
      send_item(op_passb, 16'h1234, 16'hBEEF, 1'b0);
      // positive plus positive into a negative result
      send_item(op_add, 16'h7FFF, 16'h0001, 1'b0);
      send_item(op_adc, 16'h4000, 16'h3FFF, 1'b1);

      // random items, a gap before roughly half of them
      while (rand_sent < NUM_RANDOM) begin
         if ($random(seed) & 1)
            idle_cycle();
         op_code = 3'($random(seed));
         send_item(alu_op_e'(op_code), 16'($random(seed)), 16'($random(seed)),
                   1'($random(seed)));
         rand_sent++;
      end
      idle_cycle();

      // drain, then a few spare cycles to catch stray valids
      while (exp_q.size() != 0)
         @(negedge clk);
      repeat (4) @(negedge clk);

      if (checked == NUM_DIRECTED + NUM_RANDOM) begin
         $display("Verification passed");
         $finish;
      end else begin
         abort_run($sformatf("run ended with %0d of %0d planned items checked",
                             checked, NUM_DIRECTED + NUM_RANDOM));
      end
   end

endmodule

`default_nettype wire
